// ==== hdl/ts_pkg.sv ====
package ts_pkg;

	// Stream constants.
	localparam logic [7:0] ts_sync_byte = 8'h47;
	localparam int ts_packet_bytes = 188;
	localparam int ts_packet_words = 47;

	typedef logic [5:0] ts_word_index_t;
	typedef logic [7:0] ts_byte_index_t;
	typedef logic [12:0] ts_pid_t;

	// One aligned stream byte.
	// The pid field holds only when first is set.
	typedef struct packed {
		logic [7:0] data;
		logic first;
		ts_pid_t pid;
		logic valid;
	} ts_beat_t;

	// Single byte-lane write into the packet memory.
	typedef struct packed {
		logic en;
		logic bank;
		ts_word_index_t addr;
		logic [1:0] lane;
		logic [7:0] byte_data;
	} ts_ram_wr_t;

	// Software controls seen by the capture logic.
	typedef struct packed {
		logic run_enable;
		ts_pid_t pid;
	} ts_cfg_t;

endpackage

// ==== hdl/ts_sync_align.sv ====
`timescale 1ns/1ns

module ts_sync_align (
	input logic mpeg_clk,
	input logic S_AXI_ARESETN,
	input logic [7:0] mpeg_data,
	input logic mpeg_valid,
	input logic mpeg_sync,
	output ts_pkg::ts_beat_t beat
);

	logic [2:0] sync_q;
	logic [7:0] data_d1;
	logic [7:0] data_d2;
	logic [7:0] data_d3;
	logic start;

	logic beat_valid;
	logic beat_first;
	logic [7:0] beat_data;
	ts_pkg::ts_pid_t beat_pid;

	// Oldest stage must carry both the strobe and the sync byte.
	assign start = sync_q[2] && (data_d3 == ts_pkg::ts_sync_byte);

	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			sync_q <= '0;
			beat_valid <= 1'b0;
			beat_first <= 1'b0;
		end else begin
			beat_valid <= mpeg_valid;
			if (mpeg_valid) begin
				sync_q <= {sync_q[1:0], mpeg_sync};
				beat_first <= start;
			end
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (mpeg_valid) begin
			data_d1 <= mpeg_data;
			data_d2 <= data_d1;
			data_d3 <= data_d2;
			beat_data <= data_d3;
			// PID is 5 bits of the second byte and all of the third.
			beat_pid <= {data_d2[4:0], data_d1};
		end
	end

	assign beat = '{
		data: beat_data,
		first: beat_first,
		pid: beat_pid,
		valid: beat_valid
	};

endmodule

// ==== hdl/pid_filter_regs.sv ====
`timescale 1ns/1ns

module pid_filter_regs #(
	parameter int DATA_WIDTH = 32
) (
	input logic mpeg_clk,
	input logic S_AXI_ARESETN,
	input logic cfg_we,
	input logic [1:0] cfg_addr,
	input logic [DATA_WIDTH-1:0] cfg_wdata,
	output logic [DATA_WIDTH-1:0] cfg_rdata,
	input logic captured,
	output ts_pkg::ts_cfg_t cfg
);

	logic [15:0] capture_count;

	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			cfg.run_enable <= 1'b0;
			cfg.pid <= 13'h1fff;
			capture_count <= '0;
		end else begin
			if (cfg_we) begin
				case (cfg_addr)
					2'd0: cfg.run_enable <= cfg_wdata[0];
					2'd1: cfg.pid <= cfg_wdata[$bits(ts_pkg::ts_pid_t)-1:0];
					default: ;
				endcase
			end
			// Count saturates rather than wrapping.
			if (captured && (capture_count != 16'hffff)) begin
				capture_count <= capture_count + 16'd1;
			end
		end
	end

	always_comb begin
		case (cfg_addr)
			2'd0: cfg_rdata = DATA_WIDTH'(cfg.run_enable);
			2'd1: cfg_rdata = DATA_WIDTH'(cfg.pid);
			2'd2: cfg_rdata = DATA_WIDTH'(capture_count);
			default: cfg_rdata = '0;
		endcase
	end

endmodule

// ==== hdl/packet_capture.sv ====
`timescale 1ns/1ns

module packet_capture (
	input logic mpeg_clk,
	input logic S_AXI_ARESETN,
	input ts_pkg::ts_beat_t beat,
	input ts_pkg::ts_cfg_t cfg,
	input logic pump_enable,
	output ts_pkg::ts_ram_wr_t wr,
	output logic read_bank,
	output logic captured
);

	logic matched;
	ts_pkg::ts_byte_index_t byte_idx;
	logic write_bank;
	logic next_bank;
	logic start;
	logic accept;

	assign start = beat.valid && beat.first;
	assign accept = start && cfg.run_enable && (beat.pid == cfg.pid);

	// While pumping the readable bank is frozen and the write bank is reused.
	assign next_bank = pump_enable ? write_bank : ~write_bank;
	assign read_bank = ~write_bank;

	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			matched <= 1'b0;
			byte_idx <= '0;
			write_bank <= 1'b0;
			wr <= '0;
			captured <= 1'b0;
		end else begin
			wr.en <= 1'b0;
			captured <= 1'b0;
			if (accept) begin
				matched <= 1'b1;
				byte_idx <= ts_pkg::ts_byte_index_t'(1);
				write_bank <= next_bank;
				wr.en <= 1'b1;
				wr.bank <= next_bank;
				wr.addr <= '0;
				wr.lane <= '0;
				wr.byte_data <= beat.data;
			end else if (start) begin
				matched <= 1'b0;
			end else if (beat.valid && matched && (byte_idx < ts_pkg::ts_packet_bytes)) begin
				// Byte n lands in word n/4, lane n mod 4.
				wr.en <= 1'b1;
				wr.bank <= write_bank;
				wr.addr <= byte_idx[7:2];
				wr.lane <= byte_idx[1:0];
				wr.byte_data <= beat.data;
				byte_idx <= byte_idx + 1'b1;
				captured <= (byte_idx ==
					ts_pkg::ts_byte_index_t'(ts_pkg::ts_packet_bytes - 1));
			end
		end
	end

endmodule

// ==== hdl/packet_ram.sv ====
`timescale 1ns/1ns

module packet_ram (
	input logic mpeg_clk,
	input ts_pkg::ts_ram_wr_t wr,
	input logic rd_bank,
	input ts_pkg::ts_word_index_t rd_addr,
	output logic [31:0] rd_data
);

	// Ping-pong banks, one packet each.
	logic [31:0] mem [2][ts_pkg::ts_packet_words];

	always_ff @(posedge mpeg_clk) begin
		if (wr.en) begin
			mem[wr.bank][wr.addr][{wr.lane, 3'b000} +: 8] <= wr.byte_data;
		end
		rd_data <= mem[rd_bank][rd_addr];
	end

endmodule

// ==== hdl/packet_pump.sv ====
`timescale 1ns/1ns

module packet_pump #(
	parameter int DATA_WIDTH = 32
) (
	input logic mpeg_clk,
	input logic S_AXI_ARESETN,
	input logic pump_enable,
	output ts_pkg::ts_word_index_t rd_addr,
	input logic [31:0] rd_data,
	output logic [DATA_WIDTH-1:0] out_data,
	output ts_pkg::ts_word_index_t out_data_index,
	output logic out_valid,
	output logic ready_for_read
);

	localparam ts_pkg::ts_word_index_t last_word =
		ts_pkg::ts_word_index_t'(ts_pkg::ts_packet_words - 1);

	ts_pkg::ts_word_index_t addr_q;
	ts_pkg::ts_word_index_t pend_idx;
	logic req_q;
	logic issued_q;
	logic pend_q;

	assign rd_addr = addr_q;

	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN || !pump_enable) begin
			addr_q <= '0;
			req_q <= 1'b0;
			issued_q <= 1'b0;
			pend_q <= 1'b0;
			pend_idx <= '0;
			out_valid <= 1'b0;
			out_data_index <= '0;
			ready_for_read <= 1'b0;
		end else begin
			// Request stage walks the packet once per pump.
			if (req_q) begin
				if (addr_q == last_word) begin
					req_q <= 1'b0;
					issued_q <= 1'b1;
				end else begin
					addr_q <= addr_q + 1'b1;
				end
			end else if (!issued_q) begin
				req_q <= 1'b1;
			end

			// Memory read takes one cycle.
			pend_q <= req_q;
			pend_idx <= addr_q;

			out_valid <= pend_q;
			if (pend_q) begin
				out_data_index <= pend_idx;
			end
			if (out_valid && (out_data_index == last_word)) begin
				ready_for_read <= 1'b1;
			end
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (pend_q) begin
			out_data <= DATA_WIDTH'(rd_data);
		end
	end

endmodule

// ==== hdl/ts_monitor_top.sv ====
`timescale 1ns/1ns

module ts_monitor_top #(
	parameter int DATA_WIDTH = 32
) (
	input logic mpeg_clk,
	input logic S_AXI_ARESETN,
	input logic [7:0] mpeg_data,
	input logic mpeg_valid,
	input logic mpeg_sync,
	input logic cfg_we,
	input logic [1:0] cfg_addr,
	input logic [DATA_WIDTH-1:0] cfg_wdata,
	output logic [DATA_WIDTH-1:0] cfg_rdata,
	input logic pump_enable,
	output logic [DATA_WIDTH-1:0] out_data,
	output ts_pkg::ts_word_index_t out_data_index,
	output logic out_valid,
	output logic ready_for_read
);

	ts_pkg::ts_beat_t beat;
	ts_pkg::ts_cfg_t cfg;
	ts_pkg::ts_ram_wr_t wr;
	ts_pkg::ts_word_index_t rd_addr;
	logic [31:0] rd_data;
	logic read_bank;
	logic captured;

	ts_sync_align align_i (
		.mpeg_clk(mpeg_clk),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.mpeg_data(mpeg_data),
		.mpeg_valid(mpeg_valid),
		.mpeg_sync(mpeg_sync),
		.beat(beat)
	);

	pid_filter_regs #(
		.DATA_WIDTH(DATA_WIDTH)
	) regs_i (
		.mpeg_clk(mpeg_clk),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.cfg_we(cfg_we),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg_rdata(cfg_rdata),
		.captured(captured),
		.cfg(cfg)
	);

	packet_capture capture_i (
		.mpeg_clk(mpeg_clk),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.beat(beat),
		.cfg(cfg),
		.pump_enable(pump_enable),
		.wr(wr),
		.read_bank(read_bank),
		.captured(captured)
	);

	packet_ram ram_i (
		.mpeg_clk(mpeg_clk),
		.wr(wr),
		.rd_bank(read_bank),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	packet_pump #(
		.DATA_WIDTH(DATA_WIDTH)
	) pump_i (
		.mpeg_clk(mpeg_clk),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.pump_enable(pump_enable),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.out_data(out_data),
		.out_data_index(out_data_index),
		.out_valid(out_valid),
		.ready_for_read(ready_for_read)
	);

endmodule

// ==== verif/tb_ts_monitor.sv ====
`timescale 1ns/1ns

module tb_ts_monitor;

	logic mpeg_clk;
	logic S_AXI_ARESETN;
	logic [7:0] mpeg_data;
	logic mpeg_valid;
	logic mpeg_sync;
	logic cfg_we;
	logic [1:0] cfg_addr;
	logic [31:0] cfg_wdata;
	logic [31:0] cfg_rdata;
	logic pump_enable;
	logic [31:0] out_data;
	ts_pkg::ts_word_index_t out_data_index;
	logic out_valid;
	logic ready_for_read;

	logic [31:0] rng_state = 32'h2317b84f;
	logic [7:0] tx_pkt [188];
	// Reference copy of both memory banks.
	logic [7:0] model_bank [2][188];
	logic model_wbank;
	logic model_run;
	int model_count;
	ts_pkg::ts_pid_t target_pid;
	int test_errors;
	int timing_errors;
	int pass_count;
	int fail_count;
	logic [31:0] rd_value;

	ts_monitor_top #(.DATA_WIDTH(32)) dut_i (.*);

	initial begin
		mpeg_clk = 1'b0;
		forever #10 mpeg_clk = ~mpeg_clk;
	end

	function automatic logic [31:0] next_random();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic ts_pkg::ts_pid_t pick_pid(input logic force_target);
		logic [31:0] r;
		r = next_random();
		if (force_target || r[0]) begin
			return target_pid;
		end
		// Decoy differs from the target in at least one bit.
		return target_pid ^ ts_pkg::ts_pid_t'(1 + r[20:1] % 13'h1ffe);
	endfunction

	task automatic send_byte(input logic [7:0] data, input logic sync);
		mpeg_data = data;
		mpeg_valid = 1'b1;
		mpeg_sync = sync;
		@(negedge mpeg_clk);
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		if (next_random() % 6 == 0) begin
			repeat (1 + next_random() % 3) @(negedge mpeg_clk);
		end
	endtask

	task automatic send_packet(input logic sync, input logic [7:0] first,
			input ts_pkg::ts_pid_t pid);
		logic [31:0] r;
		int i;
		r = next_random();
		tx_pkt[0] = first;
		tx_pkt[1] = {r[7:5], pid[12:8]};
		tx_pkt[2] = pid[7:0];
		for (i = 3; i < 188; i++) begin
			r = next_random();
			// Stray sync bytes inside the payload.
			tx_pkt[i] = (r[11:8] == 4'h0) ? ts_pkg::ts_sync_byte : r[7:0];
		end
		for (i = 0; i < 188; i++) begin
			send_byte(tx_pkt[i], sync && (i == 0));
		end
		if (sync && (first == ts_pkg::ts_sync_byte) && (pid == target_pid) && model_run) begin
			if (!pump_enable) begin
				model_wbank = ~model_wbank;
			end
			for (i = 0; i < 188; i++) begin
				model_bank[model_wbank][i] = tx_pkt[i];
			end
			model_count++;
		end
	endtask

	// Pushes the last three bytes out of the alignment delay line.
	task automatic flush_stream();
		repeat (3) send_byte(8'h00, 1'b0);
		// Capture and the packet counter settle two cycles later.
		repeat (2) @(negedge mpeg_clk);
	endtask

	task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
		cfg_we = 1'b1;
		cfg_addr = addr;
		cfg_wdata = data;
		@(negedge mpeg_clk);
		cfg_we = 1'b0;
	endtask

	task automatic read_reg(input logic [1:0] addr, output logic [31:0] data);
		cfg_addr = addr;
		@(negedge mpeg_clk);
		data = cfg_rdata;
	endtask

	task automatic check_count();
		read_reg(2'd2, rd_value);
		if (rd_value !== 32'(model_count)) begin
			$display("Fail cfg_rdata count expected %h got %h", 32'(model_count), rd_value);
			test_errors++;
		end
	endtask

	task automatic drop_pump();
		pump_enable = 1'b0;
		@(negedge mpeg_clk);
		if (ready_for_read !== 1'b0) begin
			$display("Fail ready_for_read expected %h got %h", 1'b0, ready_for_read);
			timing_errors++;
		end
	endtask

	task automatic pump_packet(input logic keep_high);
		logic [31:0] exp_word;
		logic rb;
		int got;
		int n;
		rb = ~model_wbank;
		pump_enable = 1'b1;
		n = 0;
		while (!out_valid && n < 10) begin
			@(negedge mpeg_clk);
			n++;
		end
		if (!out_valid) begin
			$display("out_valid did not rise after pump_enable was raised");
			timing_errors++;
		end else if (n != 3) begin
			$display("Fail out_valid latency expected %h got %h", 3, n);
			timing_errors++;
		end
		got = 0;
		n = 0;
		while (!ready_for_read && n < 100) begin
			if (out_valid) begin
				if (got < 47) begin
					exp_word = {model_bank[rb][4*got+3], model_bank[rb][4*got+2],
						model_bank[rb][4*got+1], model_bank[rb][4*got]};
					if (out_data !== exp_word) begin
						$display("Fail out_data word %0d expected %h got %h",
							got, exp_word, out_data);
						test_errors++;
					end
					if (out_data_index !== 6'(got)) begin
						$display("Fail out_data_index expected %h got %h",
							6'(got), out_data_index);
						test_errors++;
					end
				end
				got++;
			end
			@(negedge mpeg_clk);
			n++;
		end
		if (!ready_for_read) begin
			$display("ready_for_read did not rise after the pump");
			test_errors++;
		end
		if (got != 47) begin
			$display("Fail out_valid word count expected %h got %h", 47, got);
			test_errors++;
		end
		if (!keep_high) begin
			drop_pump();
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			$display("%s: ok", name);
			pass_count++;
		end else begin
			$display("%s: %0d errors", name, test_errors);
			fail_count++;
		end
		test_errors = 0;
	endtask

	initial begin
		int k;
		S_AXI_ARESETN = 1'b0;
		mpeg_data = '0;
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		cfg_we = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		pump_enable = 1'b0;
		model_wbank = 1'b0;
		model_run = 1'b0;
		model_count = 0;
		test_errors = 0;
		timing_errors = 0;
		pass_count = 0;
		fail_count = 0;
		repeat (16) @(negedge mpeg_clk);
		S_AXI_ARESETN = 1'b1;

		read_reg(2'd0, rd_value);
		if (rd_value !== 32'h0) begin
			$display("Fail cfg_rdata run expected %h got %h", 32'h0, rd_value);
			test_errors++;
		end
		read_reg(2'd1, rd_value);
		if (rd_value !== 32'h1fff) begin
			$display("Fail cfg_rdata pid expected %h got %h", 32'h1fff, rd_value);
			test_errors++;
		end
		target_pid = ts_pkg::ts_pid_t'(next_random() % 32'h1fff);
		write_reg(2'd1, 32'(target_pid));
		write_reg(2'd0, 32'h1);
		model_run = 1'b1;
		read_reg(2'd1, rd_value);
		if (rd_value !== 32'(target_pid)) begin
			$display("Fail cfg_rdata pid expected %h got %h", 32'(target_pid), rd_value);
			test_errors++;
		end
		read_reg(2'd0, rd_value);
		if (rd_value !== 32'h1) begin
			$display("Fail cfg_rdata run expected %h got %h", 32'h1, rd_value);
			test_errors++;
		end
		finish_test("register access");

		// Two matches first so both banks hold known packets.
		for (k = 0; k < 10; k++) begin
			send_packet(1'b1, ts_pkg::ts_sync_byte, pick_pid(k < 2));
		end
		flush_stream();
		check_count();
		pump_packet(1'b0);
		finish_test("filtering");

		send_packet(1'b0, ts_pkg::ts_sync_byte, target_pid);
		send_packet(1'b1, 8'h46, target_pid);
		send_packet(1'b0, ts_pkg::ts_sync_byte, target_pid);
		flush_stream();
		check_count();
		pump_packet(1'b0);
		finish_test("false starts");

		write_reg(2'd0, 32'h0);
		model_run = 1'b0;
		repeat (3) send_packet(1'b1, ts_pkg::ts_sync_byte, target_pid);
		flush_stream();
		check_count();
		pump_packet(1'b0);
		write_reg(2'd0, 32'h1);
		model_run = 1'b1;
		finish_test("run control");

		pump_packet(1'b1);
		send_packet(1'b1, ts_pkg::ts_sync_byte, target_pid);
		send_packet(1'b1, ts_pkg::ts_sync_byte, target_pid);
		flush_stream();
		drop_pump();
		pump_packet(1'b0);
		// Next accepted start exposes the packet written during the pump.
		send_packet(1'b1, ts_pkg::ts_sync_byte, target_pid);
		flush_stream();
		pump_packet(1'b0);
		check_count();
		finish_test("pump protection");

		test_errors = timing_errors;
		finish_test("pump timing");

		$display("tests passed %0d failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
hdl/ts_pkg.sv
hdl/ts_sync_align.sv
hdl/pid_filter_regs.sv
hdl/packet_capture.sv
hdl/packet_ram.sv
hdl/packet_pump.sv
hdl/ts_monitor_top.sv
verif/tb_ts_monitor.sv

// ==== Bender.yml ====
package:
  name: ts_monitor

sources:
  - hdl/ts_pkg.sv
  - hdl/ts_sync_align.sv
  - hdl/pid_filter_regs.sv
  - hdl/packet_capture.sv
  - hdl/packet_ram.sv
  - hdl/packet_pump.sv
  - hdl/ts_monitor_top.sv
  - target: test
    files:
      - verif/tb_ts_monitor.sv
